// ==== filelist.f ====
+incdir+logic
logic/fb_pkg.sv
logic/display_timings_480p.sv
logic/bram_sdp.sv
logic/line_drawer.sv
logic/fb_scanout.sv
logic/top_line.sv
tests/top_line_properties.sv
tests/tb_top_line.sv

// ==== logic/bram_sdp.sv ====
//********************************************************************
// simple dual-port block ram
// one write port, one registered read port, read-first on collision
//********************************************************************
`timescale 1ns/1ps

module bram_sdp #(
    parameter int WIDTH = 8,     // data bits per word
    parameter int DEPTH = 256    // words
) (
    input  logic                     clk_pix,
    input  logic                     we,          // write enable
    input  logic [$clog2(DEPTH)-1:0] addr_write,
    input  logic [$clog2(DEPTH)-1:0] addr_read,
    input  logic [WIDTH-1:0]         data_in,
    output logic [WIDTH-1:0]         data_out     // one cycle after addr_read
);

    logic [WIDTH-1:0] memory [DEPTH];

    // bram powers up cleared, picture starts black
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            memory[i] = '0;
        end
    end

    // same-address read returns old word
    always_ff @(posedge clk_pix) begin
        if (we) begin
            memory[addr_write] <= data_in;
        end
        data_out <= memory[addr_read];
    end

endmodule

// ==== logic/display_timings_480p.sv ====
//********************************************************************
// 640x480 display timing generator
// signed beam position, registered active-low syncs, frame pulse
//********************************************************************
`timescale 1ns/1ps
`include "fb_macros.svh"

module display_timings_480p (
    input  logic                              clk_pix,
    input  logic                              reset,
    output logic signed [fb_pkg::CORDW-1:0]   sx,      // beam column
    output logic signed [fb_pkg::CORDW-1:0]   sy,      // beam row
    output logic                              hsync,   // active low
    output logic                              vsync,   // active low
    output logic                              frame    // start of frame
);

    import fb_pkg::*;

    // sync windows in signed coords
    // front porch follows the active area, wrapping through H_STA
    localparam logic signed [CORDW-1:0] HS_STA = H_STA + `H_FP;    // -144
    localparam logic signed [CORDW-1:0] HS_END = HS_STA + `H_SYNC; // exclusive
    localparam logic signed [CORDW-1:0] VS_STA = V_STA + `V_FP;    // -35
    localparam logic signed [CORDW-1:0] VS_END = VS_STA + `V_SYNC; // exclusive

    logic signed [CORDW-1:0] sx_next;
    logic signed [CORDW-1:0] sy_next;
    logic                    hs_next;
    logic                    vs_next;

    // next beam position
    always_comb begin
        if (sx == HA_END) begin    // end of line
            sx_next = H_STA;
            sy_next = (sy == VA_END) ? V_STA : sy + 1'b1;
        end else begin
            sx_next = sx + 1'b1;
            sy_next = sy;
        end
    end

    // syncs follow the next position so they line up with sx/sy
    always_comb begin
        hs_next = ~(sx_next >= HS_STA && sx_next < HS_END);
        vs_next = ~(sy_next >= VS_STA && sy_next < VS_END);  // moves at line start
    end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx    <= H_STA;    // park at top left of blanking
            sy    <= V_STA;
            hsync <= 1'b1;
            vsync <= 1'b1;
            frame <= 1'b1;     // so the first frame starts on release
        end else begin
            sx    <= sx_next;
            sy    <= sy_next;
            hsync <= hs_next;
            vsync <= vs_next;
            frame <= (sx_next == H_STA) && (sy_next == V_STA);  // every 420000 clocks
        end
    end

endmodule

// ==== logic/fb_macros.svh ====
//********************************************************************
// framebuffer line demo constants
// 640x480 display timing, framebuffer geometry and colour depth
//********************************************************************
`ifndef FB_MACROS_SVH
`define FB_MACROS_SVH

// horizontal timing, pixel clocks
`define H_RES   640     // active pixels
`define H_FP    16      // front porch
`define H_SYNC  96      // sync pulse
`define H_BP    48      // back porch, 800 total

// vertical timing, lines
`define V_RES   480     // active lines
`define V_FP    10      // front porch
`define V_SYNC  2       // sync pulse
`define V_BP    33      // back porch, 525 total

// framebuffer, one bit per pixel
`define FB_WIDTH    160
`define FB_HEIGHT   120
`define FB_LINE_ROW 60  // row filled by the drawer

// vga dac depth per channel
`define COLR_BITS   4

`endif

// ==== logic/fb_pkg.sv ====
//********************************************************************
// framebuffer line demo package
// widths and coordinate bounds derived from the timing constants
//********************************************************************
`include "fb_macros.svh"

package fb_pkg;

    // signed screen coordinates, blanking sits below zero
    localparam int CORDW = 16;

    // first coordinate of a line and of a frame
    localparam logic signed [CORDW-1:0] H_STA = CORDW'(-(`H_FP + `H_SYNC + `H_BP));  // -160
    localparam logic signed [CORDW-1:0] V_STA = CORDW'(-(`V_FP + `V_SYNC + `V_BP));  // -45

    // last active coordinate
    localparam logic signed [CORDW-1:0] HA_END = CORDW'(`H_RES - 1);  // 639
    localparam logic signed [CORDW-1:0] VA_END = CORDW'(`V_RES - 1);  // 479

    // framebuffer sizing
    localparam int FB_PIXELS = `FB_WIDTH * `FB_HEIGHT;  // 19200
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);       // 15 bits
    localparam int FB_XW     = $clog2(`FB_WIDTH);       // column counter

    // full intensity on one channel
    localparam logic [`COLR_BITS-1:0] COLR_ON = '1;

endpackage

// ==== logic/fb_scanout.sv ====
//********************************************************************
// framebuffer scanout
// reads pixels in step with the beam and drives registered vga
//********************************************************************
`timescale 1ns/1ps
`include "fb_macros.svh"

module fb_scanout (
    input  logic                              clk_pix,
    input  logic signed [fb_pkg::CORDW-1:0]   sx,             // beam column
    input  logic signed [fb_pkg::CORDW-1:0]   sy,             // beam row
    input  logic                              hsync,
    input  logic                              vsync,
    input  logic                              frame,          // start of frame
    output logic [fb_pkg::FB_ADDRW-1:0]       fb_addr_read,
    input  logic                              fb_colr_read,   // one cycle late
    output logic                              vga_hsync,
    output logic                              vga_vsync,
    output logic [`COLR_BITS-1:0]             vga_r,
    output logic [`COLR_BITS-1:0]             vga_g,
    output logic [`COLR_BITS-1:0]             vga_b
);

    import fb_pkg::*;

    logic paint;      // beam inside framebuffer area
    logic paint_p1;   // aligned with ram data
    logic hsync_p1;
    logic vsync_p1;
    logic pix_on;

    // top left 160x120 of the screen
    always_comb begin
        paint = (sx >= 0 && sx < `FB_WIDTH && sy >= 0 && sy < `FB_HEIGHT);
    end

    // linear read address
    // starts at zero so no lookahead needed
    always_ff @(posedge clk_pix) begin
        if (frame) begin
            fb_addr_read <= '0;                    // back to pixel 0
        end else if (paint) begin
            fb_addr_read <= fb_addr_read + 1'b1;   // only inside area
        end
    end

    // match the one-cycle ram read
    always_ff @(posedge clk_pix) begin
        paint_p1 <= paint;
        hsync_p1 <= hsync;
        vsync_p1 <= vsync;
    end

    always_comb pix_on = paint_p1 && fb_colr_read;

    // registered outputs, two clocks behind the beam
    always_ff @(posedge clk_pix) begin
        vga_hsync <= hsync_p1;
        vga_vsync <= vsync_p1;
        vga_r     <= pix_on ? COLR_ON : '0;   // monochrome, all channels alike
        vga_g     <= pix_on ? COLR_ON : '0;
        vga_b     <= pix_on ? COLR_ON : '0;
    end

endmodule

// ==== logic/line_drawer.sv ====
//********************************************************************
// one-shot line drawer
// fills framebuffer row FB_LINE_ROW on the first frame after reset
//********************************************************************
`timescale 1ns/1ps
`include "fb_macros.svh"

module line_drawer (
    input  logic                          clk_pix,
    input  logic                          reset,
    input  logic                          frame,          // start of frame
    output logic                          fb_we,          // write strobe
    output logic [fb_pkg::FB_ADDRW-1:0]   fb_addr_write,
    output logic                          fb_colr_write   // pixel value
);

    import fb_pkg::*;

    // fsm encoding
    localparam logic [1:0] IDLE = 2'd0;  // waiting for frame
    localparam logic [1:0] DRAW = 2'd1;  // one pixel per clock
    localparam logic [1:0] DONE = 2'd2;  // parked until reset

    // first pixel of the target row
    localparam logic [FB_ADDRW-1:0] LINE_ADDR = FB_ADDRW'(`FB_LINE_ROW * `FB_WIDTH);
    localparam logic [FB_XW-1:0]    LAST_COL  = FB_XW'(`FB_WIDTH - 1);

    logic [1:0]       state;
    logic [FB_XW-1:0] cnt_draw;  // column being written

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            state <= IDLE;
            fb_we <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (frame) begin
                        fb_we         <= 1'b1;      // first write next cycle
                        fb_addr_write <= LINE_ADDR;
                        fb_colr_write <= 1'b1;      // white
                        cnt_draw      <= '0;
                        state         <= DRAW;
                    end
                end
                DRAW: begin
                    if (cnt_draw == LAST_COL) begin
                        fb_we <= 1'b0;              // 160 writes issued
                        state <= DONE;
                    end else begin
                        fb_addr_write <= fb_addr_write + 1'b1;
                        cnt_draw      <= cnt_draw + 1'b1;
                    end
                end
                DONE: begin
                    fb_we <= 1'b0;  // nothing more to draw
                end
                default: state <= DONE;
            endcase
        end
    end

endmodule

// ==== logic/top_line.sv ====
//********************************************************************
// framebuffer line demo top
// timing, line drawer, 1-bit framebuffer and vga scanout
//********************************************************************
`timescale 1ns/1ps
`include "fb_macros.svh"

module top_line (
    input  logic                   clk_pix,     // 25.2 MHz pixel clock
    input  logic                   reset,       // sync, active high
    output logic                   vga_hsync,
    output logic                   vga_vsync,
    output logic [`COLR_BITS-1:0]  vga_r,
    output logic [`COLR_BITS-1:0]  vga_g,
    output logic [`COLR_BITS-1:0]  vga_b
);

    import fb_pkg::*;

    // beam
    logic signed [CORDW-1:0] sx;
    logic signed [CORDW-1:0] sy;
    logic                    hsync;
    logic                    vsync;
    logic                    frame;

    // framebuffer ports
    logic                fb_we;
    logic [FB_ADDRW-1:0] fb_addr_write;
    logic [FB_ADDRW-1:0] fb_addr_read;
    logic                fb_colr_write;
    logic                fb_colr_read;

    display_timings_480p u_timings (
        .clk_pix (clk_pix),
        .reset   (reset),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .frame   (frame)
    );

    // writes row 60 once, during top blanking
    line_drawer u_drawer (
        .clk_pix       (clk_pix),
        .reset         (reset),
        .frame         (frame),
        .fb_we         (fb_we),
        .fb_addr_write (fb_addr_write),
        .fb_colr_write (fb_colr_write)
    );

    bram_sdp #(
        .WIDTH (1),          // one bit per pixel
        .DEPTH (FB_PIXELS)
    ) u_framebuffer (
        .clk_pix    (clk_pix),
        .we         (fb_we),
        .addr_write (fb_addr_write),
        .addr_read  (fb_addr_read),
        .data_in    (fb_colr_write),
        .data_out   (fb_colr_read)
    );

    fb_scanout u_scanout (
        .clk_pix      (clk_pix),
        .sx           (sx),
        .sy           (sy),
        .hsync        (hsync),
        .vsync        (vsync),
        .frame        (frame),
        .fb_addr_read (fb_addr_read),
        .fb_colr_read (fb_colr_read),
        .vga_hsync    (vga_hsync),
        .vga_vsync    (vga_vsync),
        .vga_r        (vga_r),
        .vga_g        (vga_g),
        .vga_b        (vga_b)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the framebuffer line demo testbench with Verilator.
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal \
    --timescale 1ns/1ps \
    --top-module tb_top_line \
    -f filelist.f \
    -o tb_top_line_sim

# the simulator may exit non-zero on a failure, the log decides
./obj_dir/tb_top_line_sim +verilator+error+limit+1000000 > sim.log 2>&1 || true

cat sim.log

if grep -q "Result: FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "Result: PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"

// ==== tests/tb_top_line.sv ====
//********************************************************************
// testbench for the framebuffer line demo
// rebuilds the beam from the vga syncs and checks every frame pixel
//********************************************************************
`timescale 1ns/1ps
`include "fb_macros.svh"

module tb_top_line;

    localparam int LINE_CYCLES  = 800;                // clocks per line
    localparam int FRAME_CYCLES = 420000;             // 800 x 525
    localparam int HS_LEAD      = `H_SYNC + `H_BP;    // hsync edge to column 0
    localparam int VS_LEAD      = `V_SYNC + `V_BP;    // vsync line to row 0
    localparam int SHOW_LIMIT   = 10;                 // fail lines shown per test

    logic                  clk_pix;
    logic                  reset;
    logic                  vga_hsync;
    logic                  vga_vsync;
    logic [`COLR_BITS-1:0] vga_r;
    logic [`COLR_BITS-1:0] vga_g;
    logic [`COLR_BITS-1:0] vga_b;

    logic [31:0] lcg_state;     // random state for the mid-frame reset
    string       test_name;
    int          test_errors;
    int          tests_run;
    int          tests_failed;

    top_line DUT (
        .clk_pix   (clk_pix),
        .reset     (reset),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_r     (vga_r),
        .vga_g     (vga_g),
        .vga_b     (vga_b)
    );

    // 125 MHz stand-in for the pixel clock
    initial begin
        clk_pix = 1'b0;
        forever #4 clk_pix = ~clk_pix;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // reference image, one white row across the framebuffer width
    function automatic logic [`COLR_BITS-1:0] expected_colour(input int row, input int col);
        if (row == `FB_LINE_ROW && col >= 0 && col < `FB_WIDTH) begin
            return '1;
        end
        return '0;
    endfunction

    function automatic logic sync_level(input bit vert);
        return vert ? vga_vsync : vga_hsync;
    endfunction

    task automatic abort_run(input string what);
        $display("timeout: %s", what);
        $display("Result: FAILED");
        $finish;
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests_run++;
        if (test_errors == 0) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, test_errors);
        end
    endtask

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            if (test_errors < SHOW_LIMIT) begin
                $display("FAIL %s: %s expected %0d, actual %0d", test_name, what,
                         expected, actual);
            end
            test_errors++;
        end
    endtask

    task automatic check_pixel(input int row, input int col, input logic [`COLR_BITS-1:0] exp);
        assert (vga_r === exp && vga_g === exp && vga_b === exp) else begin
            if (test_errors < SHOW_LIMIT) begin
                $display("FAIL %s: row %0d col %0d expected %h, actual r %h g %h b %h",
                         test_name, row, col, exp, vga_r, vga_g, vga_b);
            end
            test_errors++;
        end
    endtask

    // returns on the first negedge that sees the sync low after high
    task automatic wait_sync_fall(input bit vert, input int limit);
        logic prev;
        int   n;
        n    = 0;
        prev = sync_level(vert);
        @(negedge clk_pix);
        while (!(prev === 1'b1 && sync_level(vert) === 1'b0)) begin
            if (n >= limit) begin
                abort_run($sformatf("no falling edge on %s within %0d cycles",
                                    vert ? "vga_vsync" : "vga_hsync", limit));
            end
            prev = sync_level(vert);
            @(negedge clk_pix);
            n++;
        end
    endtask

    task automatic reset_dut();
        reset = 1'b1;
        repeat (5) @(negedge clk_pix);
        reset = 1'b0;
    endtask

    // syncs sit high and the screen is dark before the first hsync
    task automatic check_idle();
        for (int i = 0; i < 16; i++) begin
            check_value("vga_hsync", 1, vga_hsync);
            check_value("vga_vsync", 1, vga_vsync);
            check_pixel(-VS_LEAD - `V_FP, i - 160, '0);   // top left of blanking
            @(negedge clk_pix);
        end
    endtask

    // one frame, row -35 to 479, column -144 up to the next hsync edge
    task automatic check_frame();
        int row;
        int col;
        wait_sync_fall(1'b1, FRAME_CYCLES + LINE_CYCLES);
        for (row = -VS_LEAD; row < `V_RES; row++) begin
            wait_sync_fall(1'b0, LINE_CYCLES + 16);  // 16 clocks after vsync on row -35
            for (col = -HS_LEAD; col < LINE_CYCLES - HS_LEAD - 1; col++) begin
                check_pixel(row, col, expected_colour(row, col));
                @(negedge clk_pix);
            end
        end
    endtask

    // low time and period, counted from one falling edge to the next
    task automatic measure_sync(input bit vert, input int exp_low, input int exp_period);
        int cyc;
        int low_len;
        wait_sync_fall(vert, exp_period + LINE_CYCLES);
        cyc = 0;
        while (sync_level(vert) !== 1'b1) begin
            if (cyc > exp_period) begin
                abort_run("sync stuck low");
            end
            @(negedge clk_pix);
            cyc++;
        end
        low_len = cyc;
        while (sync_level(vert) !== 1'b0) begin
            if (cyc > exp_period + LINE_CYCLES) begin
                abort_run("sync stuck high");
            end
            @(negedge clk_pix);
            cyc++;
        end
        check_value(vert ? "vsync low cycles" : "hsync low cycles", exp_low, low_len);
        check_value(vert ? "vsync period" : "hsync period", exp_period, cyc);
    endtask

    initial begin
        int delay;
        int prop_fails;
        reset        = 1'b1;   // held from time zero
        lcg_state    = 32'h45b1f631;
        tests_run    = 0;
        tests_failed = 0;

        begin_test("reset_idle");
        reset_dut();
        check_idle();
        end_test();

        begin_test("frame1_image");  // drawer fills row 60 in top blanking
        check_frame();
        end_test();

        begin_test("frame2_image");  // drawer done, ram keeps the line
        check_frame();
        end_test();

        begin_test("sync_timing");
        measure_sync(1'b0, `H_SYNC, LINE_CYCLES);
        measure_sync(1'b1, `V_SYNC * LINE_CYCLES, FRAME_CYCLES);
        end_test();

        begin_test("reset_mid_frame");
        lcg_state = lcg_next(lcg_state);
        delay     = int'(lcg_state % FRAME_CYCLES);
        repeat (delay) @(negedge clk_pix);
        reset_dut();
        check_idle();
        check_frame();
        end_test();

        begin_test("bound_properties");
        prop_fails = DUT.u_props.fail_count;
        check_value("concurrent assertion failures", 0, prop_fails);
        end_test();

        $display("tests %0d, passed %0d, failed %0d", tests_run, tests_run - tests_failed,
                 tests_failed);
        if (tests_failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/top_line_properties.sv ====
//********************************************************************
// concurrent checks on the framebuffer line demo
// sync width, monochrome output, blanking and drawer write burst
//********************************************************************
`timescale 1ns/1ps
`include "fb_macros.svh"

module top_line_properties (
    input logic                  clk_pix,
    input logic                  reset,
    input logic                  vga_hsync,
    input logic                  vga_vsync,
    input logic [`COLR_BITS-1:0] vga_r,
    input logic [`COLR_BITS-1:0] vga_g,
    input logic [`COLR_BITS-1:0] vga_b,
    input logic                  fb_we      // drawer write strobe
);

    int hs_low_run;       // low samples of vga_hsync so far
    int we_run;           // back to back writes so far
    int fail_count = 0;   // read by the testbench at the end

    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hs_low_run <= 0;
            we_run     <= 0;
        end else begin
            hs_low_run <= vga_hsync ? 0 : hs_low_run + 1;
            we_run     <= fb_we ? we_run + 1 : 0;
        end
    end

    // full 96 clock pulse, never cut short
    a_hsync_width: assert property (@(posedge clk_pix) disable iff (reset)
        $rose(vga_hsync) |-> hs_low_run == `H_SYNC)
        else begin
            $error("vga_hsync low pulse of %0d cycles", hs_low_run);
            fail_count++;
        end

    // and never stretched
    a_hsync_max: assert property (@(posedge clk_pix) disable iff (reset)
        !vga_hsync |-> hs_low_run < `H_SYNC)
        else begin
            $error("vga_hsync low for more than %0d cycles", `H_SYNC);
            fail_count++;
        end

    a_mono: assert property (@(posedge clk_pix) disable iff (reset)
        vga_r == vga_g && vga_g == vga_b)
        else begin
            $error("colour channels differ r %h g %h b %h", vga_r, vga_g, vga_b);
            fail_count++;
        end

    a_dark_in_sync: assert property (@(posedge clk_pix) disable iff (reset)
        (!vga_hsync || !vga_vsync) |-> (vga_r == '0 && vga_g == '0 && vga_b == '0))
        else begin
            $error("colour driven during a sync pulse");
            fail_count++;
        end

    a_we_burst: assert property (@(posedge clk_pix) disable iff (reset)
        fb_we |-> we_run < `FB_WIDTH)   // one row at most
        else begin
            $error("fb_we high for more than %0d cycles", `FB_WIDTH);
            fail_count++;
        end

endmodule

bind top_line top_line_properties u_props (
    .clk_pix   (clk_pix),
    .reset     (reset),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_r     (vga_r),
    .vga_g     (vga_g),
    .vga_b     (vga_b),
    .fb_we     (fb_we)
);
